/* run_sim.sh */
#!/bin/sh
# build and run tb_top with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
  --timescale 1ns/1ps \
  --top-module tb_top \
  -f verilog.f \
  -Mdir obj_dir \
  -o sim_tb_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_top 2>&1)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "Everything OK"; then
  exit 0
else
  echo "pass message not found in simulation output"
  exit 1
fi

/* test/tb_top.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_top;

  localparam int unsigned clk_mhz          = 1;
  localparam int unsigned n_times_a_second = 250000;
  localparam int unsigned w_key            = 4;
  localparam int unsigned w_led            = 8;
  localparam int unsigned w_digit          = 8;

  // four clock cycles between two strobes
  localparam int unsigned period   = clk_mhz * 1000000 / n_times_a_second;
  localparam int unsigned n_random = 24;

  // only the first digit is ever selected
  localparam logic [w_digit - 1:0] digit_on = w_digit'(1);

  logic                 clk;
  logic                 arst_n;
  logic [w_key   - 1:0] key;
  logic [w_led   - 1:0] led;
  snail_pkg::seg_t      abcdefgh;
  logic [w_digit - 1:0] digit;

  // reference model state
  logic [w_led - 1:0]      model_reg;
  snail_pkg::moore_state_t model_moore;
  snail_pkg::mealy_state_t model_mealy;

  // stimulus table
  // expected columns come from the model
  string              tbl_name[$];
  logic [w_key - 1:0] tbl_key[$];
  logic [w_led - 1:0] tbl_led[$];
  snail_pkg::seg_t    tbl_seg[$];

  // which glyphs showed up
  bit seen_none;
  bit seen_moore;
  bit seen_mealy;

  top
  #(
    .clk_mhz          (clk_mhz),
    .n_times_a_second (n_times_a_second),
    .w_key            (w_key),
    .w_led            (w_led),
    .w_digit          (w_digit)
  )
  u_dut
  (
    .clk      (clk),
    .arst_n   (arst_n),
    .key      (key),
    .led      (led),
    .abcdefgh (abcdefgh),
    .digit    (digit)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  //--------------------------------------------------------------------------
  // error handling and checks
  //--------------------------------------------------------------------------

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      stop_run($sformatf("MISMATCH %s expected %0h actual %0h", name, expected, actual));
  endtask

  // glyph for a detector pair
  function automatic snail_pkg::seg_t glyph_for(input logic moore, input logic mealy);
    if (moore && mealy)
      return snail_pkg::seg_both;
    else if (moore)
      return snail_pkg::seg_moore;
    else if (mealy)
      return snail_pkg::seg_mealy;
    else
      return snail_pkg::seg_none;
  endfunction

  //--------------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------------

  // one strobe as the model sees it
  // recognizers see the old top bit before the register shifts
  task automatic model_shift(input logic bit_in);
    logic a;
    a = model_reg[w_led - 1];
    if (!a)
      model_moore = snail_pkg::st_got0;
    else if (model_moore == snail_pkg::st_got0)
      model_moore = snail_pkg::st_match;
    else
      model_moore = snail_pkg::st_idle;
    model_mealy = a ? snail_pkg::mealy_idle : snail_pkg::mealy_got0;
    model_reg   = {model_reg[w_led - 2:0], bit_in};
  endtask

  // mealy sees the current top bit combinationally
  function automatic snail_pkg::seg_t model_glyph();
    return glyph_for(model_moore == snail_pkg::st_match,
                     (model_mealy == snail_pkg::mealy_got0) && model_reg[w_led - 1]);
  endfunction

  task automatic check_outputs(input string name, input logic [w_led - 1:0] exp_led,
                               input snail_pkg::seg_t exp_seg);
    check_value({name, " led"}, 32'(exp_led), 32'(led));
    check_value({name, " segments"}, 32'(exp_seg), 32'(abcdefgh));
    check_value({name, " digit"}, 32'(digit_on), 32'(digit));
  endtask

  //--------------------------------------------------------------------------
  // waits
  //--------------------------------------------------------------------------

  // outputs must hold until the strobe shows up
  task automatic wait_for_strobe(input string name, input logic [w_led - 1:0] hold_led,
                                 input snail_pkg::seg_t hold_seg);
    int unsigned n;
    bit          found;
    n     = 0;
    found = 1'b0;
    while (!found && n < 2 * period)
    begin
      @(negedge clk);
      n++;
      check_outputs({name, " hold"}, hold_led, hold_seg);
      if (u_dut.enable)
        found = 1'b1;
    end
    if (!found)
      stop_run($sformatf("no strobe seen within %0d cycles during %s", 2 * period, name));
  endtask

  // cycles until led moves away from the model register
  task automatic wait_led_change(input string name, output int unsigned cycles);
    bit found;
    cycles = 0;
    found  = 1'b0;
    while (!found && cycles < 2 * period + 2)
    begin
      @(negedge clk);
      cycles++;
      if (led !== model_reg)
        found = 1'b1;
      else
        check_outputs({name, " before shift"}, model_reg, model_glyph());
    end
    if (!found)
      stop_run($sformatf("led never changed during %s", name));
  endtask

  task automatic add_entry(input string name, input logic [w_key - 1:0] k);
    tbl_name.push_back(name);
    tbl_key.push_back(k);
  endtask

  //--------------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------------

  initial
  begin
    int unsigned      r;
    int unsigned      cycles;
    logic [w_led - 1:0] hold_led;
    snail_pkg::seg_t    hold_seg;

    void'($urandom(94863));
    clk         = 1'b0;
    arst_n      = 1'b0;
    key         = '0;
    model_reg   = '0;
    model_moore = snail_pkg::st_idle;
    model_mealy = snail_pkg::mealy_idle;
    seen_none   = 1'b0;
    seen_moore  = 1'b0;
    seen_mealy  = 1'b0;

    // directed patterns first with one key value per strobe
    add_entry("lead_zero", '0);
    add_entry("lead_zero", '0);
    add_entry("seq_0_1", '0);
    add_entry("seq_0_1", 4'b0001);
    add_entry("seq_1_1", 4'b0100);
    add_entry("seq_1_1", 4'b1000);
    add_entry("seq_0_0_1", '0);
    add_entry("seq_0_0_1", '0);
    add_entry("seq_0_0_1", 4'b0010);
    add_entry("seq_0_1_1", '0);
    add_entry("seq_0_1_1", 4'b0011);
    add_entry("seq_0_1_1", 4'b1111);
    add_entry("multi_bit", 4'b0110);
    add_entry("multi_bit", '0);
    add_entry("multi_bit", 4'b1001);
    add_entry("multi_bit", '0);
    // random keys with about half of them released
    for (int i = 0; i < n_random; i++)
    begin
      r = $urandom;
      add_entry("random", r[3] ? w_key'(r >> 4) : '0);
    end
    // push everything through the top end
    for (int i = 0; i < w_led; i++)
      add_entry("flush", '0);

    // reset held for 5 cycles and released on a falling edge
    repeat (5) @(negedge clk);
    check_outputs("in reset", '0, snail_pkg::seg_none);
    key    = '1;
    arst_n = 1'b1;

    // strobe period with all keys held so every shift moves led
    wait_led_change("first strobe", cycles);
    check_value("first strobe cycle", period + 1, cycles);
    model_shift(1'b1);
    check_outputs("first strobe", model_reg, model_glyph());
    for (int k = 0; k < 2; k++)
    begin
      wait_led_change("strobe period", cycles);
      check_value("strobe period cycles", period, cycles);
      model_shift(1'b1);
      check_outputs("strobe period", model_reg, model_glyph());
    end

    // expected columns from the model
    hold_led = model_reg;
    hold_seg = model_glyph();
    foreach (tbl_key[i])
    begin
      model_shift(|tbl_key[i]);
      tbl_led.push_back(model_reg);
      tbl_seg.push_back(model_glyph());
    end

    // apply the table with key changes mid period
    foreach (tbl_key[i])
    begin
      key = tbl_key[i];
      wait_for_strobe(tbl_name[i], hold_led, hold_seg);
      @(negedge clk);
      check_outputs(tbl_name[i], tbl_led[i], tbl_seg[i]);
      seen_none  |= (tbl_seg[i] == snail_pkg::seg_none);
      seen_moore |= (tbl_seg[i] == snail_pkg::seg_moore);
      seen_mealy |= (tbl_seg[i] == snail_pkg::seg_mealy);
      hold_led   = tbl_led[i];
      hold_seg   = tbl_seg[i];
    end

    // both at once would need the last bit to be 0 and 1 together
    if (!seen_none || !seen_moore || !seen_mealy)
    begin
      stop_run("the table did not produce every reachable glyph");
    end
    else
    begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
verilog/snail_pkg.sv
verilog/strobe_gen.sv
verilog/shift_reg.sv
verilog/snail_moore_fsm.sv
verilog/snail_mealy_fsm.sv
verilog/top.sv
test/tb_top.sv

/* verilog/shift_reg.sv */
`default_nettype none
`timescale 1ns/1ps

module shift_reg
#(
  parameter int unsigned depth = 8
)
(
  input  logic               clk,
  input  logic               arst_n,
  input  logic               en,
  input  logic               seq_in,
  output logic               seq_out,
  output logic [depth - 1:0] par_out
);

  //--------------------------------------------------------------------------
  // serial in, parallel out
  //--------------------------------------------------------------------------

  // new bit enters at bit 0
  // older bits move toward the msb
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      par_out <= '0;
    end
    else if (en)
    begin
      par_out <= {par_out[depth - 2:0], seq_in};
    end
  end

  // the bit about to fall off the top end
  assign seq_out = par_out[depth - 1];

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  // no enable means no movement on the next edge
  a_hold_without_en : assert property
  (
    @(posedge clk) disable iff (!arst_n)
    !en |=> $stable(par_out)
  );

endmodule

`default_nettype wire

/* verilog/snail_mealy_fsm.sv */
`default_nettype none
`timescale 1ns/1ps

module snail_mealy_fsm
(
  input  logic clk,
  input  logic arst_n,
  input  logic en,
  input  logic a,
  output logic y
);

  snail_pkg::mealy_state_t state;
  snail_pkg::mealy_state_t state_next;

  //--------------------------------------------------------------------------
  // next state
  //--------------------------------------------------------------------------

  // the state only remembers the last bit
  // a 0 arms the machine, a 1 disarms it
  always_comb
  begin
    case (state)
      snail_pkg::mealy_idle:
      begin
        if (a)
          state_next = snail_pkg::mealy_idle;
        else
          state_next = snail_pkg::mealy_got0;
      end

      snail_pkg::mealy_got0:
      begin
        if (a)
          state_next = snail_pkg::mealy_idle;
        else
          state_next = snail_pkg::mealy_got0;
      end

      default:
      begin
        state_next = snail_pkg::mealy_idle;
      end
    endcase
  end

  //--------------------------------------------------------------------------
  // state register
  //--------------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      state <= snail_pkg::mealy_idle;
    else if (en)
      state <= state_next;
  end

  // combinational output
  // fires while the 1 is still at the input
  // one strobe ahead of the moore machine
  assign y = (state == snail_pkg::mealy_got0) && a;

  // idle never reports a match
  a_no_match_in_idle : assert property
  (
    @(posedge clk) disable iff (!arst_n)
    (state == snail_pkg::mealy_idle) |-> !y
  );

endmodule

`default_nettype wire

/* verilog/snail_moore_fsm.sv */
`default_nettype none
`timescale 1ns/1ps

module snail_moore_fsm
(
  input  logic clk,
  input  logic arst_n,
  input  logic en,
  input  logic a,
  output logic y
);

  snail_pkg::moore_state_t state;
  snail_pkg::moore_state_t state_next;

  //--------------------------------------------------------------------------
  // next state
  //--------------------------------------------------------------------------

  always_comb
  begin
    // default is to hold
    state_next = state;

    case (state)
      snail_pkg::st_idle:
      begin
        // a 1 keeps us waiting
        if (!a)
          state_next = snail_pkg::st_got0;
      end

      snail_pkg::st_got0:
      begin
        // 0 then 1 seen
        if (a)
          state_next = snail_pkg::st_match;
      end

      snail_pkg::st_match:
      begin
        // a fresh 0 can start the next match right away
        if (a)
          state_next = snail_pkg::st_idle;
        else
          state_next = snail_pkg::st_got0;
      end

      default:
      begin
        state_next = snail_pkg::st_idle;
      end
    endcase
  end

  //--------------------------------------------------------------------------
  // state register
  //--------------------------------------------------------------------------

  // only moves on the strobe
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      state <= snail_pkg::st_idle;
    else if (en)
      state <= state_next;
  end

  // output from state alone
  assign y = (state == snail_pkg::st_match);

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  // the fourth code of the two bit encoding is never reached
  a_state_legal : assert property
  (
    @(posedge clk) disable iff (!arst_n)
    state inside {snail_pkg::st_idle, snail_pkg::st_got0, snail_pkg::st_match}
  );

endmodule

`default_nettype wire

/* verilog/snail_pkg.sv */
`default_nettype none

package snail_pkg;

  //--------------------------------------------------------------------------
  // recognizer state encodings
  //--------------------------------------------------------------------------

  // moore recognizer of 0 then 1
  // match lives in a state of its own
  typedef enum logic [1:0]
  {
    st_idle  = 2'd0,
    st_got0  = 2'd1,
    st_match = 2'd2
  } moore_state_t;

  // mealy recognizer of 0 then 1
  // labels carry a prefix so they do not clash with the moore set
  typedef enum logic
  {
    mealy_idle = 1'b0,
    mealy_got0 = 1'b1
  } mealy_state_t;

  //--------------------------------------------------------------------------
  // detector pair
  //--------------------------------------------------------------------------

  // mealy in the upper bit, moore in the lower
  typedef struct packed
  {
    logic mealy;
    logic moore;
  } detect_t;

  //--------------------------------------------------------------------------
  // seven segment glyphs
  //--------------------------------------------------------------------------

  // bit order a b c d e f g h, h is the dot
  typedef logic [7:0] seg_t;

  // blank digit
  localparam seg_t seg_none  = 8'b0000_0000;
  // upper square, moore hit
  localparam seg_t seg_moore = 8'b1100_0110;
  // lower square, mealy hit
  localparam seg_t seg_mealy = 8'b0011_1010;
  // an 8, both hit
  localparam seg_t seg_both  = 8'b1111_1110;

endpackage

`default_nettype wire

/* verilog/strobe_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module strobe_gen
#(
  parameter int unsigned clk_mhz          = 50,
  parameter int unsigned n_times_a_second = 3
)
(
  input  logic clk,
  input  logic arst_n,
  output logic strobe
);

  //--------------------------------------------------------------------------
  // period arithmetic
  //--------------------------------------------------------------------------

  // clock cycles between two strobes
  localparam int unsigned period = clk_mhz * 1000000 / n_times_a_second;

  // a period of one still needs a one bit counter
  localparam int unsigned w_cnt = (period > 1) ? $clog2(period) : 1;

  logic [w_cnt - 1:0] cnt;

  //--------------------------------------------------------------------------
  // down counter and strobe register
  //--------------------------------------------------------------------------

  // zero after reset, reloads with period - 1 on wrap
  // so cnt reaches 1 just before edge number period
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cnt    <= '0;
      strobe <= 1'b0;
    end
    else
    begin
      if (cnt == '0)
        cnt <= w_cnt'(period - 1);
      else
        cnt <= cnt - 1'b1;

      // one cycle pulse per period
      strobe <= (cnt == w_cnt'(1)) || (period == 1);
    end
  end

  // single cycle pulse unless the clock itself is the strobe
  a_strobe_one_cycle : assert property
  (
    @(posedge clk) disable iff (!arst_n)
    (period > 1) && strobe |=> !strobe
  );

endmodule

`default_nettype wire

/* verilog/top.sv */
`default_nettype none
`timescale 1ns/1ps

module top
#(
  parameter int unsigned clk_mhz          = 50,
  parameter int unsigned n_times_a_second = 3,
  parameter int unsigned w_key            = 4,
  parameter int unsigned w_led            = 8,
  parameter int unsigned w_digit          = 8
)
(
  input  logic                 clk,
  input  logic                 arst_n,

  // keys and leds
  input  logic [w_key   - 1:0] key,
  output logic [w_led   - 1:0] led,

  // seven segment display
  output snail_pkg::seg_t      abcdefgh,
  output logic [w_digit - 1:0] digit
);

  //--------------------------------------------------------------------------
  // internal nets
  //--------------------------------------------------------------------------

  logic               enable;
  logic               key_any;
  logic               fsm_in;
  logic               moore_fsm_out;
  logic               mealy_fsm_out;
  snail_pkg::detect_t det;

  // any pressed key counts as a 1
  assign key_any = |key;

  //--------------------------------------------------------------------------
  // datapath
  //--------------------------------------------------------------------------

  // a few pulses per second
  strobe_gen
  #(
    .clk_mhz          (clk_mhz),
    .n_times_a_second (n_times_a_second)
  )
  i_strobe_gen
  (
    .clk    (clk),
    .arst_n (arst_n),
    .strobe (enable)
  );

  // led shows the stream, top bit feeds the recognizers
  shift_reg
  #(
    .depth (w_led)
  )
  i_shift_reg
  (
    .clk     (clk),
    .arst_n  (arst_n),
    .en      (enable),
    .seq_in  (key_any),
    .seq_out (fsm_in),
    .par_out (led)
  );

  snail_moore_fsm i_moore_fsm
  (
    .clk    (clk),
    .arst_n (arst_n),
    .en     (enable),
    .a      (fsm_in),
    .y      (moore_fsm_out)
  );

  snail_mealy_fsm i_mealy_fsm
  (
    .clk    (clk),
    .arst_n (arst_n),
    .en     (enable),
    .a      (fsm_in),
    .y      (mealy_fsm_out)
  );

  //--------------------------------------------------------------------------
  // display decode
  //--------------------------------------------------------------------------

  assign det.mealy = mealy_fsm_out;
  assign det.moore = moore_fsm_out;

  // one glyph per detector combination
  always_comb
  begin
    case (det)
      2'b01:   abcdefgh = snail_pkg::seg_moore;
      2'b10:   abcdefgh = snail_pkg::seg_mealy;
      2'b11:   abcdefgh = snail_pkg::seg_both;
      default: abcdefgh = snail_pkg::seg_none;
    endcase
  end

  // only the first digit is lit
  assign digit = w_digit'(1);

  // moore match is always preceded by a mealy match on the strobe edge
  a_mealy_leads_moore : assert property
  (
    @(posedge clk) disable iff (!arst_n)
    $rose(moore_fsm_out) |-> $past(mealy_fsm_out)
  );

endmodule

`default_nettype wire
